/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - source/cpu_pkg.sv
  - source/datapath_ctrl_if.sv
  - source/alu.sv
  - source/opcode_decode.sv
  - source/cycle_sequencer.sv
  - source/reg_datapath.sv
  - source/cpu_core.sv
  - target: simulation
    files:
      - verif/mem_model.sv
      - verif/cpu_core_tb.sv

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_DATA_W      8
`define CPU_ADDR_W      16

// first fetch address after reset
`define CPU_BOOT_ADDR   16'h0200
`define CPU_ZERO_PAGE   8'h00       // high byte in zero page mode
`define CPU_OPC_NOP     8'hEA

// status bits, 6502 layout
`define CPU_FLAG_N      8'h80
`define CPU_FLAG_V      8'h40
`define CPU_FLAG_Z      8'h02
`define CPU_FLAG_C      8'h01

`endif

/* sim.f */
+incdir+include
source/cpu_pkg.sv
source/datapath_ctrl_if.sv
source/alu.sv
source/opcode_decode.sv
source/cycle_sequencer.sv
source/reg_datapath.sv
source/cpu_core.sv
verif/mem_model.sv
verif/cpu_core_tb.sv

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module alu import cpu_pkg::*; (
    input  wire  [`CPU_DATA_W-1:0] i_ai,
    input  wire  [`CPU_DATA_W-1:0] i_bi,
    input  wire                    i_carry,
    input  var   alu_op_e          i_op,
    output logic [`CPU_DATA_W-1:0] o_out,
    output logic                   o_n,
    output logic                   o_v,
    output logic                   o_z,
    output logic                   o_c
);
    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0] sum;     // extra bit is the carry out
    logic                 is_add;

    assign sum = {1'b0, i_ai} + {1'b0, i_bi} + {{`CPU_DATA_W{1'b0}}, i_carry};
    assign is_add = (i_op == ALU_ADD);

    always_comb begin
        case (i_op)
            ALU_OR:  o_out = i_ai | i_bi;
            ALU_AND: o_out = i_ai & i_bi;
            ALU_XOR: o_out = i_ai ^ i_bi;
            default: o_out = sum[MSB:0];
        endcase
    end

    assign o_n = o_out[MSB];
    assign o_z = (o_out == '0);
    assign o_c = is_add & sum[`CPU_DATA_W];
    // operands of equal sign giving a sum of the other sign
    assign o_v = is_add & (i_ai[MSB] == i_bi[MSB]) & (sum[MSB] != i_ai[MSB]);

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module cpu_core import cpu_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire  [`CPU_DATA_W-1:0] i_data,
    output logic [`CPU_ADDR_W-1:0] o_addr,
    output logic [`CPU_DATA_W-1:0] o_wdata,
    output logic                   o_rw
);
    addr_mode_e mode;
    cyc_state_e state;
    addr_sel_e  addr_sel;
    logic       rd_op, ld_op, st_op;
    logic       single_byte, undefined;
    logic       pc_inc, p_carry;

    datapath_ctrl_if ctrl_ex ();    // execute word from the decoder
    datapath_ctrl_if ctrl ();       // word applied this cycle

    opcode_decode u_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_fetch_byte   (i_data),
        .i_decode_cycle (state == ST_DECODE),
        .i_p_carry      (p_carry),
        .o_mode         (mode),
        .o_read         (rd_op),
        .o_load         (ld_op),
        .o_store        (st_op),
        .o_single_byte  (single_byte),
        .o_undefined    (undefined),
        .ctrl_ex        (ctrl_ex.ex)
    );

    cycle_sequencer u_seq (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_mode        (mode),
        .i_read        (rd_op),
        .i_load        (ld_op),
        .i_store       (st_op),
        .i_single_byte (single_byte),
        .i_undefined   (undefined),
        .o_state       (state),
        .o_pc_inc      (pc_inc),
        .o_addr_sel    (addr_sel),
        .ctrl_ex       (ctrl_ex.dp),
        .ctrl          (ctrl.seq)
    );

    reg_datapath u_datapath (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_data     (i_data),
        .i_pc_inc   (pc_inc),
        .i_addr_sel (addr_sel),
        .ctrl       (ctrl.dp),
        .o_addr     (o_addr),
        .o_wdata    (o_wdata),
        .o_rw       (o_rw),
        .o_p_carry  (p_carry)
    );

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // aaa bbb cc opcode layout
    typedef struct packed {
        logic [2:0] group;      // operation within the class
        logic [2:0] mode;       // addressing mode field
        logic [1:0] op_class;   // 01 accumulator, 10 X, 00 Y
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    typedef enum logic [2:0] {DB_DATA, DB_PCL, DB_PCH, DB_A, DB_ZERO} db_src_e;

    typedef enum logic [2:0] {SB_A, SB_X, SB_Y, SB_ADD, SB_DATA, SB_ZERO} sb_src_e;

    typedef enum logic [1:0] {RES_DB, RES_SB, RES_ADD} res_src_e;

    typedef enum logic [2:0] {DST_A, DST_X, DST_Y, DST_MEM, DST_NONE} res_dst_e;

    typedef enum logic [1:0] {IN_BUS, IN_INV, IN_ONES, IN_ZERO} alu_in_e;

    typedef enum logic [1:0] {CARRY_ZERO, CARRY_ONE, CARRY_C} carry_sel_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_OR, ALU_AND, ALU_XOR} alu_op_e;

    typedef enum logic [2:0] {
        MODE_IMM, MODE_ZPG, MODE_ABS, MODE_IMPL, MODE_UNDEF
    } addr_mode_e;

    // address source for the memory bus
    typedef enum logic [1:0] {ADDR_PC, ADDR_ZPG, ADDR_ABS, ADDR_HOLD} addr_sel_e;

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_FETCH,
        ST_DECODE,
        ST_ZPG_RD,
        ST_ABS_HI,
        ST_ABS_RD,
        ST_JAM
    } cyc_state_e;

endpackage

`default_nettype wire

/* source/cycle_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cycle_sequencer import cpu_pkg::*; (
    input  wire          i_clk,
    input  wire          i_rst,
    input  var  addr_mode_e i_mode,
    input  wire          i_read,
    input  wire          i_load,
    input  wire          i_store,
    input  wire          i_single_byte,
    input  wire          i_undefined,
    output cyc_state_e   o_state,
    output logic         o_pc_inc,
    output addr_sel_e    o_addr_sel,
    datapath_ctrl_if.dp  ctrl_ex,
    datapath_ctrl_if.seq ctrl
);
    cyc_state_e state_d;
    logic       compute_result;
    logic       save_result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_state <= ST_BOOT;
        end else begin
            o_state <= state_d;
        end
    end

    always_comb begin
        case (o_state)
            ST_BOOT:   state_d = ST_FETCH;
            ST_FETCH:  state_d = ST_DECODE;
            ST_DECODE: begin
                if (i_undefined) begin
                    state_d = ST_JAM;
                end else begin
                    case (i_mode)
                        MODE_ZPG: state_d = ST_ZPG_RD;
                        MODE_ABS: state_d = ST_ABS_HI;
                        default:  state_d = ST_FETCH;   // immediate and implied
                    endcase
                end
            end
            ST_ZPG_RD: state_d = ST_FETCH;
            ST_ABS_HI: state_d = ST_ABS_RD;
            ST_ABS_RD: state_d = ST_FETCH;
            default:   state_d = ST_JAM;
        endcase
    end

    // address and phase of each cycle
    always_comb begin
        o_pc_inc = 1'b0;
        o_addr_sel = ADDR_PC;
        compute_result = 1'b0;
        save_result = 1'b0;
        case (o_state)
            ST_FETCH: begin
                o_pc_inc = 1'b1;
                compute_result = i_read | i_load | i_single_byte; // operand is on the bus now
            end
            ST_DECODE: begin
                o_pc_inc = !i_single_byte;
                save_result = i_read | i_load;  // write back the previous result
            end
            ST_ZPG_RD: begin
                o_addr_sel = ADDR_ZPG;
                save_result = i_store;
            end
            ST_ABS_HI: o_pc_inc = 1'b1;         // low byte parks in the hold register
            ST_ABS_RD: begin
                o_addr_sel = ADDR_ABS;
                save_result = i_store;
            end
            ST_JAM: o_addr_sel = ADDR_HOLD;
            default: ;
        endcase
    end

    always_comb begin
        // data plus zero into the hold register with nothing stored
        ctrl.db_src = DB_DATA;
        ctrl.sb_src = SB_ZERO;
        ctrl.res_src = RES_ADD;
        ctrl.res_dst = DST_NONE;
        ctrl.alu_op = ALU_ADD;
        ctrl.ai_src = IN_BUS;
        ctrl.bi_src = IN_BUS;
        ctrl.carry_sel = CARRY_ZERO;
        ctrl.alu_mask = '0;
        ctrl.set_mask = '0;
        ctrl.clear_mask = '0;
        if (compute_result || save_result) begin
            ctrl.db_src = ctrl_ex.db_src;
            ctrl.sb_src = ctrl_ex.sb_src;
        end
        if (compute_result) begin
            ctrl.alu_op = ctrl_ex.alu_op;
            ctrl.ai_src = ctrl_ex.ai_src;
            ctrl.bi_src = ctrl_ex.bi_src;
            ctrl.carry_sel = ctrl_ex.carry_sel;
            ctrl.alu_mask = ctrl_ex.alu_mask;
            ctrl.set_mask = ctrl_ex.set_mask;
            ctrl.clear_mask = ctrl_ex.clear_mask;
        end
        if (save_result) begin
            ctrl.res_src = ctrl_ex.res_src;
            ctrl.res_dst = ctrl_ex.res_dst;
        end
    end

    // no operand cycle after an implied opcode
    a_implied_to_fetch: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_state == ST_DECODE && i_single_byte) |=> o_state == ST_FETCH);

endmodule

`default_nettype wire

/* source/datapath_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

interface datapath_ctrl_if import cpu_pkg::*; ();
    db_src_e                db_src;
    sb_src_e                sb_src;
    res_src_e               res_src;
    res_dst_e               res_dst;
    alu_op_e                alu_op;
    alu_in_e                ai_src;     // shapes the secondary bus
    alu_in_e                bi_src;     // shapes the data bus
    carry_sel_e             carry_sel;
    logic [`CPU_DATA_W-1:0] alu_mask;   // flags taken from the ALU
    logic [`CPU_DATA_W-1:0] set_mask;
    logic [`CPU_DATA_W-1:0] clear_mask;

    modport ex (output db_src, sb_src, res_src, res_dst, alu_op, ai_src, bi_src,
                carry_sel, alu_mask, set_mask, clear_mask);

    // final word, the sequencer reads the ex copy through dp
    modport seq (output db_src, sb_src, res_src, res_dst, alu_op, ai_src, bi_src,
                 carry_sel, alu_mask, set_mask, clear_mask);

    modport dp (input db_src, sb_src, res_src, res_dst, alu_op, ai_src, bi_src,
                carry_sel, alu_mask, set_mask, clear_mask);
endinterface

`default_nettype wire

/* source/opcode_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module opcode_decode import cpu_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire  [`CPU_DATA_W-1:0] i_fetch_byte,
    input  wire                    i_decode_cycle,
    input  wire                    i_p_carry,
    output addr_mode_e             o_mode,
    output logic                   o_read,
    output logic                   o_load,
    output logic                   o_store,
    output logic                   o_single_byte,
    output logic                   o_undefined,
    datapath_ctrl_if.ex            ctrl_ex
);
    localparam logic [7:0] OPC_CLC = 8'h18;
    localparam logic [7:0] OPC_SEC = 8'h38;

    opcode_u    ir;
    opcode_u    opc;        // byte being decoded this cycle
    addr_mode_e ir_mode;
    sb_src_e    reg_sb;
    res_dst_e   reg_dst;

    function automatic addr_mode_e mode_of(opcode_u op);
        addr_mode_e m;
        logic       acc_op;
        logic       xy_op;
        m = MODE_UNDEF;
        acc_op = (op.f.op_class == 2'b01);
        xy_op = (op.f.op_class inside {2'b00, 2'b10}) && (op.f.group inside {3'b100, 3'b101});
        if (op.raw inside {OPC_CLC, OPC_SEC, `CPU_OPC_NOP}) begin
            m = MODE_IMPL;
        end else if (acc_op || xy_op) begin
            case (op.f.mode)
                3'b001:  m = MODE_ZPG;
                3'b011:  m = MODE_ABS;
                3'b000:  m = (xy_op && op.f.group == 3'b101) ? MODE_IMM : MODE_UNDEF; // LDX/LDY
                3'b010:  m = (acc_op && op.f.group != 3'b100) ? MODE_IMM : MODE_UNDEF; // no STA #
                default: m = MODE_UNDEF;
            endcase
        end
        return m;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ir.raw <= `CPU_OPC_NOP;
        end else if (i_decode_cycle) begin
            ir.raw <= i_fetch_byte;
        end
    end

    assign opc.raw = i_decode_cycle ? i_fetch_byte : ir.raw;

    assign o_mode = mode_of(opc);
    assign o_single_byte = (o_mode == MODE_IMPL);
    assign o_undefined = (o_mode == MODE_UNDEF);

    // class and execute word follow the latched instruction
    assign ir_mode = mode_of(ir);

    always_comb begin
        case (ir.f.op_class)
            2'b00: begin
                reg_sb = SB_Y;
                reg_dst = DST_Y;
            end
            2'b10: begin
                reg_sb = SB_X;
                reg_dst = DST_X;
            end
            default: begin
                reg_sb = SB_A;
                reg_dst = DST_A;
            end
        endcase
    end

    always_comb begin
        o_read = 1'b0;
        o_load = 1'b0;
        o_store = 1'b0;
        ctrl_ex.db_src = DB_DATA;
        ctrl_ex.sb_src = SB_A;
        ctrl_ex.res_src = RES_ADD;
        ctrl_ex.res_dst = DST_NONE;
        ctrl_ex.alu_op = ALU_ADD;
        ctrl_ex.ai_src = IN_BUS;
        ctrl_ex.bi_src = IN_BUS;
        ctrl_ex.carry_sel = CARRY_ZERO;
        ctrl_ex.alu_mask = '0;
        ctrl_ex.set_mask = '0;
        ctrl_ex.clear_mask = '0;
        if (ir_mode == MODE_IMPL) begin
            if (ir.raw == OPC_CLC) ctrl_ex.clear_mask = `CPU_FLAG_C;
            if (ir.raw == OPC_SEC) ctrl_ex.set_mask = `CPU_FLAG_C;
        end else if (ir_mode != MODE_UNDEF) begin
            if (ir.f.group == 3'b100) begin
                o_store = 1'b1;
                ctrl_ex.sb_src = reg_sb;        // register straight to memory
                ctrl_ex.res_src = RES_SB;
                ctrl_ex.res_dst = DST_MEM;
            end else if (ir.f.group == 3'b101) begin
                o_load = 1'b1;
                ctrl_ex.ai_src = IN_ZERO;       // data + 0 sets N and Z
                ctrl_ex.res_dst = reg_dst;
                ctrl_ex.alu_mask = `CPU_FLAG_N | `CPU_FLAG_Z;
            end else begin
                o_read = 1'b1;
                ctrl_ex.res_dst = DST_A;
                ctrl_ex.alu_mask = `CPU_FLAG_N | `CPU_FLAG_Z;
                case (ir.f.group)
                    3'b000: ctrl_ex.alu_op = ALU_OR;
                    3'b001: ctrl_ex.alu_op = ALU_AND;
                    3'b010: ctrl_ex.alu_op = ALU_XOR;
                    3'b110: begin                   // CMP drops the A - M result
                        ctrl_ex.bi_src = IN_INV;
                        ctrl_ex.carry_sel = CARRY_ONE;
                        ctrl_ex.res_dst = DST_NONE;
                        ctrl_ex.alu_mask = `CPU_FLAG_N | `CPU_FLAG_Z | `CPU_FLAG_C;
                    end
                    default: begin                  // ADC or SBC on the inverted byte
                        if (ir.f.group[2]) ctrl_ex.bi_src = IN_INV;
                        ctrl_ex.carry_sel = i_p_carry ? CARRY_ONE : CARRY_ZERO;
                        ctrl_ex.alu_mask = `CPU_FLAG_N | `CPU_FLAG_V | `CPU_FLAG_Z | `CPU_FLAG_C;
                    end
                endcase
            end
        end
    end

    // a store always has an operand address
    a_store_addressed: assert property (@(posedge i_clk) disable iff (i_rst)
        o_store |-> ir_mode inside {MODE_ZPG, MODE_ABS});

endmodule

`default_nettype wire

/* source/reg_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module reg_datapath import cpu_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire  [`CPU_DATA_W-1:0] i_data,
    input  wire                    i_pc_inc,
    input  var   addr_sel_e        i_addr_sel,
    datapath_ctrl_if.dp            ctrl,
    output logic [`CPU_ADDR_W-1:0] o_addr,
    output logic [`CPU_DATA_W-1:0] o_wdata,
    output logic                   o_rw,
    output logic                   o_p_carry
);
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] addr_q;     // last address held in jam
    logic [`CPU_DATA_W-1:0] a, x, y, p;
    logic [`CPU_DATA_W-1:0] add;        // adder hold register
    logic [`CPU_DATA_W-1:0] db, sb, res;
    logic [`CPU_DATA_W-1:0] ai, bi, alu_out, alu_status;
    logic                   alu_ci, alu_n, alu_v, alu_z, alu_c;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= `CPU_BOOT_ADDR;
            a <= '0;
            x <= '0;
            y <= '0;
            p <= '0;
        end else begin
            pc <= pc + {{(`CPU_ADDR_W-1){1'b0}}, i_pc_inc};
            p <= ~ctrl.clear_mask & (ctrl.set_mask | (ctrl.alu_mask & alu_status) |
                                     (~ctrl.alu_mask & p));
            case (ctrl.res_dst)
                DST_A:   a <= res;
                DST_X:   x <= res;
                DST_Y:   y <= res;
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        add <= alu_out;
        addr_q <= o_addr;
    end

    always_comb begin
        case (ctrl.db_src)
            DB_DATA: db = i_data;
            DB_PCL:  db = pc[`CPU_DATA_W-1:0];
            DB_PCH:  db = pc[`CPU_ADDR_W-1:`CPU_DATA_W];
            DB_A:    db = a;
            default: db = '0;
        endcase
        case (ctrl.sb_src)
            SB_A:    sb = a;
            SB_X:    sb = x;
            SB_Y:    sb = y;
            SB_ADD:  sb = add;
            SB_DATA: sb = i_data;
            default: sb = '0;
        endcase
        case (ctrl.res_src)
            RES_DB:  res = db;
            RES_SB:  res = sb;
            default: res = add;
        endcase
    end

    always_comb begin
        case (ctrl.ai_src)
            IN_BUS:  ai = sb;
            IN_INV:  ai = ~sb;
            IN_ONES: ai = '1;
            default: ai = '0;
        endcase
        case (ctrl.bi_src)
            IN_BUS:  bi = db;
            IN_INV:  bi = ~db;          // subtract and compare
            IN_ONES: bi = '1;
            default: bi = '0;
        endcase
        case (ctrl.carry_sel)
            CARRY_ONE: alu_ci = 1'b1;
            CARRY_C:   alu_ci = o_p_carry;
            default:   alu_ci = 1'b0;
        endcase
    end

    alu u_alu (
        .i_ai    (ai),
        .i_bi    (bi),
        .i_carry (alu_ci),
        .i_op    (ctrl.alu_op),
        .o_out   (alu_out),
        .o_n     (alu_n),
        .o_v     (alu_v),
        .o_z     (alu_z),
        .o_c     (alu_c)
    );

    assign alu_status = ({`CPU_DATA_W{alu_n}} & `CPU_FLAG_N) | ({`CPU_DATA_W{alu_v}} & `CPU_FLAG_V) |
                        ({`CPU_DATA_W{alu_z}} & `CPU_FLAG_Z) | ({`CPU_DATA_W{alu_c}} & `CPU_FLAG_C);
    assign o_p_carry = |(p & `CPU_FLAG_C);

    always_comb begin
        case (i_addr_sel)
            ADDR_ZPG:  o_addr = {`CPU_ZERO_PAGE, db};
            ADDR_ABS:  o_addr = {db, add};              // high byte arriving with low byte held
            ADDR_HOLD: o_addr = addr_q;
            default:   o_addr = pc;
        endcase
    end

    assign o_rw = (ctrl.res_dst != DST_MEM);
    assign o_wdata = o_rw ? '0 : res;

    // memory is written only at an operand address
    a_write_at_operand: assert property (@(posedge i_clk) disable iff (i_rst)
        (ctrl.res_dst == DST_MEM) |-> i_addr_sel inside {ADDR_ZPG, ADDR_ABS});

endmodule

`default_nettype wire

/* verif/cpu_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module cpu_core_tb;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int JAM_HOLD = 20;
    localparam int MAX_STORES = 64;

    localparam int T_BOOT = 0;
    localparam int T_LDST = 1;
    localparam int T_ARITH = 2;
    localparam int T_LOGIC = 3;
    localparam int T_CMP = 4;
    localparam int T_JAM = 5;

    localparam int M_IMM = 0;
    localparam int M_ZPG = 1;
    localparam int M_ABS = 2;

    // immediate opcodes, zero page is 4 below and absolute 4 above
    localparam logic [7:0] OPC_ORA = 8'h09;
    localparam logic [7:0] OPC_AND = 8'h29;
    localparam logic [7:0] OPC_EOR = 8'h49;
    localparam logic [7:0] OPC_ADC = 8'h69;
    localparam logic [7:0] OPC_SBC = 8'hE9;
    localparam logic [7:0] OPC_CMP = 8'hC9;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [7:0]  rdata;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        rw;

    int          seed = 76511;
    logic [15:0] gen_pc;            // next free program byte
    logic [7:0]  zp_rd;
    logic [7:0]  zp_wr;
    logic [15:0] abs_rd;
    logic [15:0] abs_wr;
    logic [7:0]  m_a;               // reference registers
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    int          n_instr = 0;
    int          n_stores = 0;
    logic [15:0] st_addr [MAX_STORES];
    logic [7:0]  st_data [MAX_STORES];
    int          st_test [MAX_STORES];
    string       test_names [6];
    int          wr_idx = 0;
    logic [15:0] jam_fetch;
    logic        jam_armed = 1'b0;
    int          jam_cycles = 0;
    logic        prog_ready = 1'b0;

    cpu_core dut (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_data  (rdata),
        .o_addr  (addr),
        .o_wdata (wdata),
        .o_rw    (rw)
    );

    mem_model u_mem (
        .i_clk   (clk),
        .i_addr  (addr),
        .i_wdata (wdata),
        .i_rw    (rw),
        .o_rdata (rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_failed(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [15:0] exp,
                                   input logic [15:0] act);
        stop_failed($sformatf("Fail %s expected %0h actual %0h", test, exp, act));
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic emit(input logic [7:0] b);
        u_mem.load_byte(gen_pc, b);
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic emit_op(input logic [7:0] opc);
        emit(opc);
        n_instr++;
    endtask

    task automatic expect_store(input int test, input logic [15:0] a, input logic [7:0] d);
        st_addr[n_stores] = a;
        st_data[n_stores] = d;
        st_test[n_stores] = test;
        n_stores++;
    endtask

    // register 0 is A, 1 is X, 2 is Y
    task automatic load_imm(input int r);
        logic [7:0] v;
        v = rand_byte();
        case (r)
            0: emit_op(8'hA9);
            1: emit_op(8'hA2);
            default: emit_op(8'hA0);
        endcase
        emit(v);
        if (r == 0) m_a = v;
        else if (r == 1) m_x = v;
        else m_y = v;
    endtask

    task automatic store_reg(input int r, input bit is_abs, input int test);
        logic [7:0] v;
        logic [7:0] opc;
        v = (r == 0) ? m_a : (r == 1) ? m_x : m_y;
        case (r)
            0: opc = 8'h85;
            1: opc = 8'h86;
            default: opc = 8'h84;
        endcase
        if (is_abs) begin
            emit_op(opc + 8'h08);       // absolute form
            emit(abs_wr[7:0]);
            emit(abs_wr[15:8]);
            expect_store(test, abs_wr, v);
            abs_wr = abs_wr + 16'd1;
        end else begin
            emit_op(opc);
            emit(zp_wr);
            expect_store(test, {`CPU_ZERO_PAGE, zp_wr}, v);
            zp_wr = zp_wr + 8'd1;
        end
    endtask

    // operand is random, preloaded in memory for zero page and absolute
    task automatic alu_op(input logic [7:0] imm_opc, input int mode);
        logic [7:0] m;
        int         t;
        m = rand_byte();
        if (mode == M_IMM) begin
            emit_op(imm_opc);
            emit(m);
        end else if (mode == M_ZPG) begin
            emit_op(imm_opc - 8'h04);
            emit(zp_rd);
            u_mem.load_byte({`CPU_ZERO_PAGE, zp_rd}, m);
            zp_rd = zp_rd + 8'd1;
        end else begin
            emit_op(imm_opc + 8'h04);
            emit(abs_rd[7:0]);
            emit(abs_rd[15:8]);
            u_mem.load_byte(abs_rd, m);
            abs_rd = abs_rd + 16'd1;
        end
        case (imm_opc)
            OPC_ORA: m_a = m_a | m;
            OPC_AND: m_a = m_a & m;
            OPC_EOR: m_a = m_a ^ m;
            OPC_ADC: begin
                t = int'(m_a) + int'(m) + int'(m_c);
                m_a = t[7:0];
                m_c = (t > 255);
            end
            OPC_SBC: begin
                // borrow is the inverse of carry
                t = int'(m_a) - int'(m) - int'(!m_c);
                m_a = t[7:0];
                m_c = (t >= 0);
            end
            default: m_c = (m_a >= m);  // CMP, A untouched
        endcase
    endtask

    task automatic set_carry(input bit c);
        emit_op(c ? 8'h38 : 8'h18);     // SEC or CLC
        m_c = c;
    endtask

    task automatic build_program();
        gen_pc = `CPU_BOOT_ADDR;
        zp_rd = 8'h10;
        zp_wr = 8'h80;
        abs_rd = 16'h4000;
        abs_wr = 16'h5000;
        m_a = '0;                       // register values after reset
        m_x = '0;
        m_y = '0;
        m_c = 1'b0;
        for (int r = 0; r < 3; r++) begin
            load_imm(r);
            store_reg(r, 1'b0, T_LDST);
            store_reg(r, 1'b1, T_LDST);
        end
        for (int i = 0; i < 4; i++) begin
            load_imm(0);
            set_carry(i[0]);
            alu_op(OPC_ADC, M_IMM);
            store_reg(0, 1'b0, T_ARITH);
            set_carry(i[1]);
            alu_op(OPC_SBC, M_IMM);
            store_reg(0, 1'b1, T_ARITH);
            emit_op(`CPU_OPC_NOP);      // carry from SBC passes through
            alu_op(OPC_ADC, M_IMM);
            store_reg(0, 1'b0, T_ARITH);
        end
        for (int mode = M_ZPG; mode <= M_ABS; mode++) begin
            load_imm(0);
            alu_op(OPC_ORA, mode);
            store_reg(0, 1'b0, T_LOGIC);
            alu_op(OPC_AND, mode);
            store_reg(0, 1'b1, T_LOGIC);
            alu_op(OPC_EOR, mode);
            store_reg(0, 1'b0, T_LOGIC);
        end
        for (int mode = M_IMM; mode <= M_ABS; mode++) begin
            load_imm(0);
            alu_op(OPC_CMP, mode);
            store_reg(0, 1'b0, T_CMP);
            alu_op(OPC_ADC, M_IMM);     // picks up the compare carry
            store_reg(0, 1'b1, T_CMP);
        end
        jam_fetch = gen_pc;
        emit_op(8'h02);                 // undefined, core jams here
    endtask

    always @(posedge clk) begin
        if (rst) begin
            wr_idx <= 0;
            jam_armed <= 1'b0;
            jam_cycles <= 0;
        end else begin
            if (!rw) wr_idx <= wr_idx + 1;
            if (addr == jam_fetch) jam_armed <= 1'b1;
            if (jam_armed) jam_cycles <= jam_cycles + 1;
        end
    end

    a_boot_addr: assert property (@(posedge clk) $fell(rst) |-> addr == `CPU_BOOT_ADDR)
        else report_mismatch(test_names[T_BOOT], `CPU_BOOT_ADDR, $sampled(addr));

    a_read_wdata: assert property (@(posedge clk) disable iff (rst) rw |-> wdata == 8'h00)
        else report_mismatch(test_names[T_BOOT], 16'h0000, $sampled(wdata));

    a_write_expected: assert property (@(posedge clk) disable iff (rst)
        !rw |-> wr_idx < n_stores)
        else stop_failed("the core wrote to memory after the last expected store");

    a_write_addr: assert property (@(posedge clk) disable iff (rst)
        (!rw && wr_idx < n_stores) |-> addr == st_addr[wr_idx])
        else report_mismatch(test_names[st_test[$sampled(wr_idx)]],
                             st_addr[$sampled(wr_idx)], $sampled(addr));

    a_write_data: assert property (@(posedge clk) disable iff (rst)
        (!rw && wr_idx < n_stores) |-> wdata == st_data[wr_idx])
        else report_mismatch(test_names[st_test[$sampled(wr_idx)]],
                             st_data[$sampled(wr_idx)], $sampled(wdata));

    // from the jam decode cycle on, the address after the opcode stays put
    a_jam_addr: assert property (@(posedge clk) disable iff (rst)
        jam_armed |-> addr == jam_fetch + 16'd1)
        else report_mismatch(test_names[T_JAM], jam_fetch + 16'd1, $sampled(addr));

    a_jam_read: assert property (@(posedge clk) disable iff (rst) jam_armed |-> rw)
        else stop_failed("the core drove a memory write while jammed");

    initial begin
        test_names = '{"boot", "load_store", "arith", "logic", "compare", "jam"};
        u_mem.fill();
        build_program();
        prog_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (jam_cycles > JAM_HOLD);
        @(negedge clk);
        if (wr_idx != n_stores) begin
            stop_failed($sformatf("the core made %0d of %0d stores before jamming",
                                  wr_idx, n_stores));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // four cycles per instruction and some slack for reset and jam
    initial begin
        wait (prog_ready);
        #((4 * n_instr + 100) * CLK_PERIOD);
        stop_failed("watchdog timeout, the core did not hold the jam state in time");
    end

endmodule

`default_nettype wire

/* verif/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module mem_model (
    input  wire                    i_clk,
    input  wire  [`CPU_ADDR_W-1:0] i_addr,
    input  wire  [`CPU_DATA_W-1:0] i_wdata,
    input  wire                    i_rw,
    output logic [`CPU_DATA_W-1:0] o_rdata
);
    localparam int DEPTH = 1 << `CPU_ADDR_W;

    logic [`CPU_DATA_W-1:0] mem [DEPTH];
    logic [`CPU_DATA_W-1:0] rd_q;       // byte read at the last rising edge

    // background bytes mix the high and low address halves
    task automatic fill();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= 8'(i ^ (i >> 8) ^ 8'h5A);
        end
        rd_q <= '0;
        o_rdata <= '0;
    endtask

    task automatic load_byte(input logic [`CPU_ADDR_W-1:0] a,
                             input logic [`CPU_DATA_W-1:0] d);
        mem[a] <= d;
    endtask

    // read data one cycle after the address
    always @(posedge i_clk) begin
        if (!i_rw) begin
            mem[i_addr] <= i_wdata;     // write commits at this edge
        end
        rd_q <= mem[i_addr];
    end

    // the core sees the byte from the falling edge on
    always @(negedge i_clk) begin
        o_rdata <= rd_q;
    end

endmodule

`default_nettype wire
